/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := dmem_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST)) hdl/dmem_cfg.svh

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
+incdir+hdl
hdl/dmem_pkg.sv
hdl/mem_latency_timer.sv
hdl/burst_buffer.sv
hdl/byte_mem_array.sv
hdl/dmem_ctrl_fsm.sv
hdl/dmem_top.sv
dv/dmem_tb.sv

/* dv/dmem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dmem_cfg.svh"

module dmem_tb;
    import dmem_pkg::*;

    localparam int DEPTH = `DMEM_DEPTH_WORDS;
    // transactions and beats summed over all tests
    localparam int NUM_TXN     = 15;
    localparam int TOTAL_BEATS = 41;
    localparam int WD_CYCLES   = 2 * TOTAL_BEATS + NUM_TXN * (`DMEM_LATENCY + 20) + 20;

    logic          clk;
    logic          rst_n;
    axi_addr_req_t ar;
    logic          ar_valid;
    logic          ar_ready;
    axi_addr_req_t aw;
    logic          aw_valid;
    logic          aw_ready;
    axi_w_t        w;
    logic          w_valid;
    logic          w_ready;
    axi_r_t        r;
    logic          r_valid;
    logic          r_ready;
    axi_b_t        b;
    logic          b_valid;
    logic          b_ready;

    // expected memory contents
    word_t      ref_mem [DEPTH];
    word_t      wdata [`DMEM_MAX_BURST];
    logic [3:0] wstrb [`DMEM_MAX_BURST];
    time        rd_end_time;
    time        aw_hs_time;

    dmem_top i_dut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    initial begin
        #(WD_CYCLES * 10);
        $display("watchdog expired after %0d cycles, DUT stopped responding", WD_CYCLES);
        $display(">>> FAIL");
        $fatal(1, "timeout");
    end

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "check failed");
        end
    endtask

    function automatic axi_resp_e expect_resp(input int unsigned idx, input int unsigned len);
        return (idx + len >= DEPTH) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
    endfunction

    task automatic ref_write(input int unsigned idx, input word_t data, input logic [3:0] strb);
        for (int lane = 0; lane < 4; lane++) begin
            if (strb[lane]) begin
                ref_mem[idx][lane*8 +: 8] = data[lane*8 +: 8];
            end
        end
    endtask

    // entered and left on a falling edge
    task automatic write_burst(input int unsigned idx, input int unsigned len);
        axi_resp_e resp;
        resp = expect_resp(idx, len);
        aw = '{addr: `DMEM_ADDR_WIDTH'(idx << 2), len: 8'(len)};
        aw_valid = 1'b1;
        #1;
        while (!aw_ready) begin
            @(negedge clk);
            #1;
        end
        aw_hs_time = $time;
        @(negedge clk);
        aw_valid = 1'b0;
        for (int unsigned i = 0; i <= len; i++) begin
            w = '{data: wdata[i], strb: wstrb[i], last: (i == len)};
            w_valid = 1'b1;
            #1;
            while (!w_ready) begin
                @(negedge clk);
                #1;
            end
            @(negedge clk);
        end
        w_valid = 1'b0;
        b_ready = 1'b1;
        #1;
        while (!b_valid) begin
            @(negedge clk);
            #1;
        end
        check_value("b.resp", 64'(resp), 64'(b.resp));
        @(negedge clk);
        b_ready = 1'b0;
        if (resp == AXI_RESP_OKAY) begin
            for (int unsigned i = 0; i <= len; i++) begin
                ref_write(idx + i, wdata[i], wstrb[i]);
            end
        end
    endtask

    task automatic read_burst(input int unsigned idx, input int unsigned len, input bit stall);
        axi_resp_e   resp;
        axi_r_t      held;
        bit          holding;
        int unsigned beat;
        resp    = expect_resp(idx, len);
        holding = 1'b0;
        beat    = 0;
        ar = '{addr: `DMEM_ADDR_WIDTH'(idx << 2), len: 8'(len)};
        ar_valid = 1'b1;
        #1;
        while (!ar_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        ar_valid = 1'b0;
        while (beat <= len) begin
            r_ready = stall ? 1'($urandom_range(0, 1)) : 1'b1;
            #1;
            // a stalled beat must stay put
            if (holding) begin
                check_value("r_valid", 64'(1), 64'(r_valid));
                check_value("r (stalled)", 64'(held), 64'(r));
            end
            if (r_valid && r_ready) begin
                if (resp == AXI_RESP_OKAY) begin
                    check_value("r.data", 64'(ref_mem[idx + beat]), 64'(r.data));
                end
                check_value("r.resp", 64'(resp), 64'(r.resp));
                check_value("r.last", 64'(beat == len), 64'(r.last));
                beat++;
                holding = 1'b0;
            end else if (r_valid) begin
                holding = 1'b1;
                held    = r;
            end
            @(negedge clk);
        end
        rd_end_time = $time;
        r_ready = 1'b0;
    endtask

    task automatic check_reset_state();
        check_value("r_valid", 64'(0), 64'(r_valid));
        check_value("b_valid", 64'(0), 64'(b_valid));
        check_value("w_ready", 64'(0), 64'(w_ready));
        check_value("ar_ready", 64'(1), 64'(ar_ready));
        check_value("aw_ready", 64'(1), 64'(aw_ready));
    endtask

    task automatic single_beat_roundtrip();
        wdata[0] = $urandom();
        wstrb[0] = 4'hf;
        write_burst(16, 0);
        read_burst(16, 0, 1'b0);
    endtask

    task automatic burst_with_backpressure();
        for (int i = 0; i < `DMEM_MAX_BURST; i++) begin
            wdata[i] = $urandom();
            wstrb[i] = 4'hf;
        end
        write_burst(100, `DMEM_MAX_BURST - 1);
        read_burst(100, `DMEM_MAX_BURST - 1, 1'b1);
    endtask

    task automatic partial_strobe_merge();
        word_t first;
        word_t second;
        first  = $urandom();
        second = $urandom();
        wdata[0] = first;
        wstrb[0] = 4'hf;
        write_burst(40, 0);
        // only lanes 0 and 2 of the second word land
        wdata[0] = second;
        wstrb[0] = 4'b0101;
        write_burst(40, 0);
        read_burst(40, 0, 1'b0);
    endtask

    task automatic out_of_range_bursts();
        for (int i = 0; i < 4; i++) begin
            wdata[i] = $urandom();
            wstrb[i] = 4'hf;
        end
        write_burst(DEPTH - 4, 3);
        for (int i = 0; i < 4; i++) begin
            wdata[i] = $urandom();
        end
        // crosses the top, so the earlier words must survive
        write_burst(DEPTH - 3, 3);
        read_burst(DEPTH - 4, 3, 1'b0);
        read_burst(DEPTH - 3, 3, 1'b0);
    endtask

    task automatic simultaneous_requests();
        wdata[0] = $urandom();
        wstrb[0] = 4'hf;
        write_burst(200, 0);
        wdata[0] = ~wdata[0];
        fork
            read_burst(200, 0, 1'b0);
            write_burst(200, 0);
        join
        check_value("read done before aw", 64'(1), 64'(rd_end_time < aw_hs_time));
        read_burst(200, 0, 1'b0);
    endtask

    initial begin
        void'($urandom(88));
        rst_n    = 1'b0;
        ar       = '0;
        ar_valid = 1'b0;
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        r_ready  = 1'b0;
        b_ready  = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_reset_state();
        single_beat_roundtrip();
        burst_with_backpressure();
        partial_strobe_merge();
        out_of_range_bursts();
        simultaneous_requests();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/burst_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dmem_cfg.svh"

module burst_buffer #(
    parameter type beat_t = logic [31:0]
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  push,
    input  beat_t push_data,
    input  logic  pop,
    output beat_t head
);
    localparam int DEPTH = `DMEM_MAX_BURST;
    localparam int PW    = $clog2(DEPTH);

    beat_t         entries [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_data;
        end
    end

    assign head = entries[rd_ptr];

    // controller must keep beat counts within one burst
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push && !pop |-> count < (PW + 1)'(DEPTH));
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> count != '0);

endmodule

`default_nettype wire

/* hdl/byte_mem_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dmem_cfg.svh"

module byte_mem_array (
    input  logic                        clk,
    input  logic [`DMEM_ADDR_WIDTH-3:0] word_addr,
    input  logic                        wr_en,
    input  dmem_pkg::word_t             wr_data,
    input  logic [3:0]                  wr_strb,
    output dmem_pkg::word_t             rd_data
);
    localparam int DEPTH = `DMEM_DEPTH_WORDS;
    localparam int IW    = $clog2(DEPTH);

    // one array per byte lane
    logic [7:0]    lanes [4][DEPTH];
    logic [IW-1:0] idx;

    assign idx = word_addr[IW-1:0];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wr_strb[lane]) begin
                    lanes[lane][idx] <= wr_data[lane*8 +: 8];
                end
            end
        end
    end

    // lane 0 is the low byte
    assign rd_data = {lanes[3][idx], lanes[2][idx], lanes[1][idx], lanes[0][idx]};

    // the range check upstream must gate every write past the top
    a_wr_in_range: assert property (@(posedge clk)
        wr_en |-> word_addr < (`DMEM_ADDR_WIDTH - 2)'(DEPTH));

endmodule

`default_nettype wire

/* hdl/dmem_cfg.svh */
`ifndef DMEM_CFG_SVH
`define DMEM_CFG_SVH

// byte address width on the AXI side
`define DMEM_ADDR_WIDTH 32

// storage size in 32-bit words
`define DMEM_DEPTH_WORDS 1024

// simulated access latency in cycles
`define DMEM_LATENCY 10

// beats per burst, also the depth of each beat buffer
`define DMEM_MAX_BURST 8

`endif

/* hdl/dmem_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dmem_cfg.svh"

module dmem_ctrl_fsm (
    input  logic                        clk,
    input  logic                        rst_n,
    input  dmem_pkg::axi_addr_req_t     ar,
    input  logic                        ar_valid,
    input  dmem_pkg::axi_addr_req_t     aw,
    input  logic                        aw_valid,
    input  logic                        w_valid,
    input  logic                        w_last,
    input  logic                        r_ready,
    input  logic                        b_ready,
    input  logic                        timer_done,
    output logic                        ar_ready,
    output logic                        aw_ready,
    output logic                        w_ready,
    output logic                        r_valid,
    output logic                        r_last,
    output dmem_pkg::axi_resp_e         r_resp,
    output logic                        b_valid,
    output dmem_pkg::axi_resp_e         b_resp,
    output logic                        timer_start,
    output logic                        rbuf_push,
    output logic                        rbuf_pop,
    output logic                        wbuf_pop,
    output logic [`DMEM_ADDR_WIDTH-3:0] mem_word_addr,
    output logic                        mem_wr_en
);
    import dmem_pkg::*;

    localparam int WAW = `DMEM_ADDR_WIDTH - 2;

    typedef enum logic [2:0] {
        S_IDLE,
        S_WR_RECV,
        S_WR_WAIT,
        S_WR_COMMIT,
        S_WR_RESP,
        S_RD_WAIT,
        S_RD_XFER,
        S_RD_SEND
    } state_e;

    state_e          state_q;
    state_e          state_d;
    axi_addr_req_t   req;
    logic [WAW:0]    end_idx;
    logic            accept;
    logic [WAW-1:0]  base_q;
    logic [7:0]      len_q;
    logic [7:0]      beat_cnt;
    logic            beat_end;
    axi_resp_e       resp_q;

    // read wins when both requests arrive together
    assign req      = ar_valid ? ar : aw;
    assign accept   = (state_q == S_IDLE) && (ar_valid || aw_valid);
    assign end_idx  = {1'b0, req.addr[`DMEM_ADDR_WIDTH-1:2]} + (WAW + 1)'(req.len);
    assign beat_end = (beat_cnt == len_q);

    assign ar_ready      = (state_q == S_IDLE);
    assign aw_ready      = (state_q == S_IDLE) && !ar_valid;
    assign w_ready       = (state_q == S_WR_RECV);
    assign r_valid       = (state_q == S_RD_SEND);
    assign r_last        = r_valid && beat_end;
    assign r_resp        = resp_q;
    assign b_valid       = (state_q == S_WR_RESP);
    assign b_resp        = resp_q;
    assign rbuf_push     = (state_q == S_RD_XFER);
    assign rbuf_pop      = r_valid && r_ready;
    assign wbuf_pop      = (state_q == S_WR_COMMIT);
    assign mem_word_addr = base_q + WAW'(beat_cnt);
    assign mem_wr_en     = wbuf_pop && (resp_q == AXI_RESP_OKAY);

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (ar_valid) begin
                    state_d = S_RD_WAIT;
                end else if (aw_valid) begin
                    state_d = S_WR_RECV;
                end
            end
            S_WR_RECV:   if (w_valid && w_last) state_d = S_WR_WAIT;
            S_WR_WAIT:   if (timer_done) state_d = S_WR_COMMIT;
            S_WR_COMMIT: if (beat_end) state_d = S_WR_RESP;
            S_WR_RESP:   if (b_ready) state_d = S_IDLE;
            S_RD_WAIT:   if (timer_done) state_d = S_RD_XFER;
            S_RD_XFER:   if (beat_end) state_d = S_RD_SEND;
            S_RD_SEND:   if (r_ready && beat_end) state_d = S_IDLE;
            default:     state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= S_IDLE;
            base_q      <= '0;
            len_q       <= '0;
            resp_q      <= AXI_RESP_OKAY;
            beat_cnt    <= '0;
            timer_start <= 1'b0;
        end else begin
            state_q <= state_d;
            // start one cycle after AR, or after the last W beat
            timer_start <= (accept && ar_valid) || (w_ready && w_valid && w_last);
            if (accept) begin
                base_q <= req.addr[`DMEM_ADDR_WIDTH-1:2];
                len_q  <= req.len;
                resp_q <= (end_idx >= (WAW + 1)'(`DMEM_DEPTH_WORDS)) ? AXI_RESP_SLVERR
                                                                      : AXI_RESP_OKAY;
            end
            // one counter covers transfer, commit and send phases
            if (rbuf_push || wbuf_pop || rbuf_pop) begin
                beat_cnt <= beat_end ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    a_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> req.len < 8'(`DMEM_MAX_BURST));
    a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
        r_valid && !r_ready |=> r_valid && $stable(r_last) && $stable(r_resp));

endmodule

`default_nettype wire

/* hdl/dmem_pkg.sv */
`default_nettype none

`include "dmem_cfg.svh"

package dmem_pkg;

    typedef enum logic [1:0] {
        AXI_RESP_OKAY   = 2'b00,
        AXI_RESP_SLVERR = 2'b10
    } axi_resp_e;

    typedef logic [31:0] word_t;

    // shared by AR and AW
    typedef struct packed {
        logic [`DMEM_ADDR_WIDTH-1:0] addr;
        // beats minus one
        logic [7:0]                  len;
    } axi_addr_req_t;

    typedef struct packed {
        word_t      data;
        logic [3:0] strb;
        logic       last;
    } axi_w_t;

    typedef struct packed {
        word_t     data;
        axi_resp_e resp;
        logic      last;
    } axi_r_t;

    typedef struct packed {
        axi_resp_e resp;
    } axi_b_t;

    // write buffer entry
    typedef struct packed {
        word_t      data;
        logic [3:0] strb;
    } mem_wbeat_t;

endpackage

`default_nettype wire

/* hdl/dmem_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dmem_cfg.svh"

module dmem_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  dmem_pkg::axi_addr_req_t ar,
    input  logic                    ar_valid,
    output logic                    ar_ready,
    input  dmem_pkg::axi_addr_req_t aw,
    input  logic                    aw_valid,
    output logic                    aw_ready,
    input  dmem_pkg::axi_w_t        w,
    input  logic                    w_valid,
    output logic                    w_ready,
    output dmem_pkg::axi_r_t        r,
    output logic                    r_valid,
    input  logic                    r_ready,
    output dmem_pkg::axi_b_t        b,
    output logic                    b_valid,
    input  logic                    b_ready
);
    import dmem_pkg::*;

    logic                        timer_start;
    logic                        timer_done;
    logic                        rbuf_push;
    logic                        rbuf_pop;
    logic                        wbuf_pop;
    logic [`DMEM_ADDR_WIDTH-3:0] mem_word_addr;
    logic                        mem_wr_en;
    word_t                       mem_rd_data;
    word_t                       rbuf_head;
    mem_wbeat_t                  wbuf_in;
    mem_wbeat_t                  wbuf_head;
    logic                        r_last;
    axi_resp_e                   r_resp;
    axi_resp_e                   b_resp;

    assign wbuf_in = '{data: w.data, strb: w.strb};
    assign r       = '{data: rbuf_head, resp: r_resp, last: r_last};
    assign b       = '{resp: b_resp};

    dmem_ctrl_fsm u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .ar            (ar),
        .ar_valid      (ar_valid),
        .aw            (aw),
        .aw_valid      (aw_valid),
        .w_valid       (w_valid),
        .w_last        (w.last),
        .r_ready       (r_ready),
        .b_ready       (b_ready),
        .timer_done    (timer_done),
        .ar_ready      (ar_ready),
        .aw_ready      (aw_ready),
        .w_ready       (w_ready),
        .r_valid       (r_valid),
        .r_last        (r_last),
        .r_resp        (r_resp),
        .b_valid       (b_valid),
        .b_resp        (b_resp),
        .timer_start   (timer_start),
        .rbuf_push     (rbuf_push),
        .rbuf_pop      (rbuf_pop),
        .wbuf_pop      (wbuf_pop),
        .mem_word_addr (mem_word_addr),
        .mem_wr_en     (mem_wr_en)
    );

    mem_latency_timer #(.LATENCY(`DMEM_LATENCY)) u_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .start (timer_start),
        .done  (timer_done)
    );

    // array words into the read side
    burst_buffer #(.beat_t(word_t)) u_rbuf (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rbuf_push),
        .push_data (mem_rd_data),
        .pop       (rbuf_pop),
        .head      (rbuf_head)
    );

    // W beats held until commit
    burst_buffer #(.beat_t(mem_wbeat_t)) u_wbuf (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (w_valid && w_ready),
        .push_data (wbuf_in),
        .pop       (wbuf_pop),
        .head      (wbuf_head)
    );

    byte_mem_array u_mem (
        .clk       (clk),
        .word_addr (mem_word_addr),
        .wr_en     (mem_wr_en),
        .wr_data   (wbuf_head.data),
        .wr_strb   (wbuf_head.strb),
        .rd_data   (mem_rd_data)
    );

endmodule

`default_nettype wire

/* hdl/mem_latency_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dmem_cfg.svh"

module mem_latency_timer #(
    parameter int LATENCY = `DMEM_LATENCY
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic done
);
    localparam int CW = $clog2(LATENCY + 1);

    logic [CW-1:0] count;
    logic          running;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count   <= '0;
            running <= 1'b0;
        end else if (start) begin
            count   <= CW'(LATENCY);
            running <= 1'b1;
        end else if (running) begin
            if (count == '0) begin
                running <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // running drops on the next edge so done lasts one cycle
    assign done = running && (count == '0);

endmodule

`default_nettype wire
